/* common/buzzer_pkg.sv */
package buzzer_pkg;

    // Bus data word.
    typedef logic [31:0] word_t;

    // Register word index, taken from addr[3:2] on the CPU side.
    typedef logic [1:0] reg_idx_t;

    // Frequencies in hertz, durations in cycles and half-period counts.
    typedef logic [31:0] count_t;

    // Number of notes that played to the end; wraps.
    typedef logic [15:0] note_cnt_t;

    // System clock rate in hertz.
    localparam count_t clk_hz = 32'd50_000_000;

    // Register map, word addressed.
    localparam reg_idx_t reg_ctrl = 2'd0;
    localparam reg_idx_t reg_freq = 2'd1;
    localparam reg_idx_t reg_dur  = 2'd2;
    localparam reg_idx_t reg_stat = 2'd3;

    // Cycles from a divider start to its done pulse.
    // One load cycle plus one cycle per quotient bit.
    localparam int div_cycles = 33;

    // A note as handed from the register block to the tone generator.
    typedef struct packed {
        count_t freq;
        count_t dur;
    } note_cmd_t;

    // Single-cycle strobes from the tone generator.
    // toggle flips the pin, finish ends a full note, abort marks a rejected note.
    typedef struct packed {
        logic toggle;
        logic finish;
        logic abort;
    } tone_evt_t;

    // Note FSM states.
    typedef enum logic [1:0] {
        st_idle,
        st_div,
        st_run,
        st_reject
    } tone_state_t;

endpackage

/* hdl/bus_regs.sv */
`timescale 1ns/1ps

module bus_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  bus_stb,
    input  logic                  we,
    input  buzzer_pkg::reg_idx_t  addr,
    input  buzzer_pkg::word_t     wdata,
    input  buzzer_pkg::tone_evt_t evt,
    input  logic                  cmd_ready,
    input  buzzer_pkg::note_cnt_t note_count,
    output buzzer_pkg::word_t     rdata,
    output buzzer_pkg::note_cmd_t cmd,
    output logic                  cmd_valid,
    output logic                  stop
);

    logic               en_q;
    logic               busy_q;
    logic               err_q;
    buzzer_pkg::count_t freq_q;
    buzzer_pkg::count_t dur_q;
    logic               wr;
    logic               frozen;

    assign wr = bus_stb && we;

    // A note is requested while enable is set and nothing is playing.
    assign cmd_valid = en_q && !busy_q;

    // Note parameters are locked from request until the note is over.
    assign frozen = cmd_valid || busy_q;

    // CPU clearing enable on a live note.
    assign stop = wr && (addr == buzzer_pkg::reg_ctrl) && !wdata[0] && en_q;

    assign cmd.freq = freq_q;
    assign cmd.dur  = dur_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q   <= 1'b0;
            busy_q <= 1'b0;
            err_q  <= 1'b0;
            freq_q <= '0;
            dur_q  <= '0;
        end else begin
            if (cmd_valid && cmd_ready) begin
                busy_q <= 1'b1;
            end
            if (evt.finish || evt.abort) begin
                en_q   <= 1'b0;
                busy_q <= 1'b0;
            end
            if (stop) begin
                busy_q <= 1'b0;
            end
            if (wr) begin
                case (addr)
                    buzzer_pkg::reg_ctrl: en_q <= wdata[0];
                    buzzer_pkg::reg_freq: if (!frozen) freq_q <= wdata;
                    buzzer_pkg::reg_dur:  if (!frozen) dur_q <= wdata;
                    buzzer_pkg::reg_stat: err_q <= 1'b0;
                    default: ;
                endcase
            end
            // A reject in the same cycle as a stat write still leaves the error visible.
            if (evt.abort) begin
                err_q <= 1'b1;
            end
        end
    end

    always_comb begin
        case (addr)
            buzzer_pkg::reg_ctrl: rdata = {31'b0, en_q};
            buzzer_pkg::reg_freq: rdata = freq_q;
            buzzer_pkg::reg_dur:  rdata = dur_q;
            default:              rdata = {note_count, 14'b0, err_q, busy_q};
        endcase
    end

    // A waiting command must not change under the tone generator.
    assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && !cmd_ready |=> $stable(cmd))
        else $error("bus_regs: note command changed while waiting for ready");

endmodule

/* tone_gen/period_div.sv */
`timescale 1ns/1ps

module period_div (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  buzzer_pkg::count_t divisor,
    output buzzer_pkg::count_t quotient,
    output logic               done
);

    localparam int iter_last = buzzer_pkg::div_cycles - 2;

    buzzer_pkg::count_t dsr_q;
    buzzer_pkg::count_t rem_q;
    buzzer_pkg::count_t dq_q;
    logic [5:0]         iter_q;
    logic               busy_q;
    logic [32:0]        trial;

    // dq_q shifts the dividend out at the top and the quotient bits in at the bottom.
    assign trial = {rem_q, dq_q[31]} - {1'b0, dsr_q};

    // Division by zero reports quotient 0 so the note is rejected.
    assign quotient = (dsr_q == '0) ? '0 : dq_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done   <= 1'b0;
            iter_q <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy_q <= 1'b1;
                iter_q <= '0;
            end else if (busy_q) begin
                iter_q <= iter_q + 6'd1;
                if (iter_q == 6'(iter_last)) begin
                    busy_q <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dsr_q <= divisor;
            rem_q <= '0;
            dq_q  <= buzzer_pkg::clk_hz;
        end else if (busy_q) begin
            // Restore on a negative trial, keep the difference otherwise.
            if (trial[32]) begin
                rem_q <= {rem_q[30:0], dq_q[31]};
            end else begin
                rem_q <= trial[31:0];
            end
            dq_q <= {dq_q[30:0], ~trial[32]};
        end
    end

    // The tone FSM relies on a fixed divide latency.
    assert property (@(posedge clk) disable iff (!rst_n)
        start |-> ##(buzzer_pkg::div_cycles) done)
        else $error("period_div: done did not follow start by the divide latency");

endmodule

/* tone_gen/tone_gen.sv */
`timescale 1ns/1ps

module tone_gen (
    input  logic                  clk,
    input  logic                  rst_n,
    input  buzzer_pkg::note_cmd_t cmd,
    input  logic                  cmd_valid,
    input  logic                  stop,
    output logic                  cmd_ready,
    output buzzer_pkg::tone_evt_t evt
);

    buzzer_pkg::tone_state_t state_q;
    buzzer_pkg::count_t      dur_q;
    buzzer_pkg::count_t      half_q;
    buzzer_pkg::count_t      period_q;
    buzzer_pkg::count_t      quotient;
    logic                    stop_pend_q;
    logic                    div_done;
    logic                    accept;
    logic                    div_go;

    assign cmd_ready = (state_q == buzzer_pkg::st_idle) && !stop;
    assign accept    = cmd_valid && cmd_ready;

    period_div i_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (accept),
        .divisor  (cmd.freq),
        .quotient (quotient),
        .done     (div_done)
    );

    // The divide result is used only if the note was not stopped meanwhile.
    assign div_go = div_done && !stop_pend_q && !stop;

    assign evt.toggle = (state_q == buzzer_pkg::st_run) && (half_q == 32'd1);
    assign evt.abort  = (state_q == buzzer_pkg::st_reject);
    assign evt.finish = ((state_q == buzzer_pkg::st_run) && (dur_q == 32'd1)) ||
                        ((state_q == buzzer_pkg::st_div) && div_go &&
                         (quotient != '0) && (dur_q == '0));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= buzzer_pkg::st_idle;
            dur_q       <= '0;
            half_q      <= '0;
            period_q    <= '0;
            stop_pend_q <= 1'b0;
        end else begin
            case (state_q)
                buzzer_pkg::st_idle: begin
                    stop_pend_q <= 1'b0;
                    if (accept) begin
                        dur_q   <= cmd.dur;
                        state_q <= buzzer_pkg::st_div;
                    end
                end
                buzzer_pkg::st_div: begin
                    // The divider cannot be cut short, so a stop waits for done.
                    if (stop) begin
                        stop_pend_q <= 1'b1;
                    end
                    if (div_done) begin
                        if (!div_go) begin
                            state_q <= buzzer_pkg::st_idle;
                        end else if (quotient == '0) begin
                            state_q <= buzzer_pkg::st_reject;
                        end else if (dur_q == '0) begin
                            state_q <= buzzer_pkg::st_idle;
                        end else begin
                            half_q   <= quotient;
                            period_q <= quotient;
                            state_q  <= buzzer_pkg::st_run;
                        end
                    end
                end
                buzzer_pkg::st_run: begin
                    dur_q <= dur_q - 32'd1;
                    if (half_q == 32'd1) begin
                        half_q <= period_q;
                    end else begin
                        half_q <= half_q - 32'd1;
                    end
                    if (stop || (dur_q == 32'd1)) begin
                        state_q <= buzzer_pkg::st_idle;
                    end
                end
                default: begin
                    state_q <= buzzer_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

/* hdl/buzz_out.sv */
`timescale 1ns/1ps

module buzz_out (
    input  logic                  clk,
    input  logic                  rst_n,
    input  buzzer_pkg::tone_evt_t evt,
    input  logic                  stop,
    output logic                  buzz,
    output logic                  note_done,
    output buzzer_pkg::note_cnt_t note_count
);

    // The pin always rests low between notes.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buzz <= 1'b0;
        end else if (evt.finish || stop) begin
            buzz <= 1'b0;
        end else if (evt.toggle) begin
            buzz <= ~buzz;
        end
    end

    // Only notes that ran their full duration are reported and counted.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            note_done  <= 1'b0;
            note_count <= '0;
        end else begin
            note_done <= evt.finish;
            if (evt.finish) begin
                note_count <= note_count + 16'd1;
            end
        end
    end

endmodule

/* hdl/buzzer_top.sv */
`timescale 1ns/1ps

module buzzer_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 bus_stb,
    input  logic                 we,
    input  buzzer_pkg::reg_idx_t addr,
    input  buzzer_pkg::word_t    wdata,
    output buzzer_pkg::word_t    rdata,
    output logic                 buzz,
    output logic                 note_done
);

    buzzer_pkg::note_cmd_t cmd;
    logic                  cmd_valid;
    logic                  cmd_ready;
    logic                  stop;
    buzzer_pkg::tone_evt_t evt;
    buzzer_pkg::note_cnt_t note_count;

    bus_regs i_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_stb    (bus_stb),
        .we         (we),
        .addr       (addr),
        .wdata      (wdata),
        .evt        (evt),
        .cmd_ready  (cmd_ready),
        .note_count (note_count),
        .rdata      (rdata),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .stop       (stop)
    );

    tone_gen i_tone (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .stop      (stop),
        .cmd_ready (cmd_ready),
        .evt       (evt)
    );

    buzz_out i_out (
        .clk        (clk),
        .rst_n      (rst_n),
        .evt        (evt),
        .stop       (stop),
        .buzz       (buzz),
        .note_done  (note_done),
        .note_count (note_count)
    );

endmodule

/* test/buzzer_checker.sv */
`timescale 1ns/1ps

module buzzer_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 buzz,
    input  logic                 note_done,
    input  buzzer_pkg::word_t    rdata,
    input  buzzer_pkg::reg_idx_t rd_addr,
    input  logic                 rd_check,
    input  buzzer_pkg::word_t    rd_expect,
    input  logic                 note_arm,
    input  logic                 note_close,
    input  buzzer_pkg::count_t   exp_freq,
    input  buzzer_pkg::count_t   exp_dur,
    input  logic                 exp_play,
    input  logic                 exp_silent,
    output int                   checks,
    output int                   errors
);

    logic               buzz_prev;
    logic               armed;
    logic               seen_done;
    buzzer_pkg::count_t rises;
    buzzer_pkg::count_t want;

    // Rising edges of the pin over one full note.
    function automatic buzzer_pkg::count_t expected_rises(input buzzer_pkg::count_t freq,
                                                          input buzzer_pkg::count_t dur);
        buzzer_pkg::count_t q;
        buzzer_pkg::count_t toggles;
        if (freq == '0 || dur == '0) begin
            return '0;
        end
        q = buzzer_pkg::clk_hz / freq;
        if (q == '0) begin
            return '0;
        end
        // A toggle due on the last cycle meets the forced low at note end and never shows.
        toggles = (dur - 32'd1) / q;
        return (toggles + 32'd1) / 32'd2;
    endfunction

    function automatic string reg_name(input buzzer_pkg::reg_idx_t a);
        case (a)
            buzzer_pkg::reg_ctrl: return "ctrl";
            buzzer_pkg::reg_freq: return "freq";
            buzzer_pkg::reg_dur:  return "dur";
            default:              return "stat";
        endcase
    endfunction

    // Everything is sampled on the falling edge, half a cycle away from any change.
    always @(negedge clk) begin
        if (!rst_n) begin
            buzz_prev = 1'b0;
            armed     = 1'b0;
            seen_done = 1'b0;
            rises     = '0;
            checks    = 0;
            errors    = 0;
        end else begin
            if (rd_check) begin
                checks = checks + 1;
                if (rdata !== rd_expect) begin
                    errors = errors + 1;
                    $display("ERROR rdata (%s): got %h, expected %h",
                             reg_name(rd_addr), rdata, rd_expect);
                end
            end
            if (note_arm) begin
                armed     = 1'b1;
                seen_done = 1'b0;
                rises     = '0;
            end else if (buzz && !buzz_prev) begin
                rises = rises + 32'd1;
            end
            if (note_done) begin
                checks = checks + 1;
                if (!armed || !exp_play || seen_done) begin
                    errors = errors + 1;
                    $display("note_done pulsed for a note that was stopped, rejected or idle");
                end else begin
                    want = expected_rises(exp_freq, exp_dur);
                    if (rises !== want) begin
                        errors = errors + 1;
                        $display("ERROR buzz rising edges: got %h, expected %h", rises, want);
                    end
                    if (buzz !== 1'b0) begin
                        errors = errors + 1;
                        $display("ERROR buzz after note_done: got %h, expected %h", buzz, 1'b0);
                    end
                end
                seen_done = 1'b1;
            end
            if (note_close) begin
                checks = checks + 1;
                if (exp_play && !seen_done) begin
                    errors = errors + 1;
                    $display("A note that should play to the end gave no note_done pulse");
                end
                if (buzz !== 1'b0) begin
                    errors = errors + 1;
                    $display("ERROR buzz at note end: got %h, expected %h", buzz, 1'b0);
                end
                if (exp_silent && rises != '0) begin
                    errors = errors + 1;
                    $display("ERROR buzz rising edges: got %h, expected %h", rises, 32'h0);
                end
                armed = 1'b0;
            end
            buzz_prev = buzz;
        end
    end

endmodule

/* test/buzzer_tb.sv */
`timescale 1ns/1ps

module buzzer_tb;

    // One note of the stimulus table; abort_after of 0 lets the note play out.
    typedef struct packed {
        buzzer_pkg::count_t freq;
        buzzer_pkg::count_t dur;
        buzzer_pkg::count_t abort_after;
    } note_row_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  bus_stb;
    logic                  we;
    buzzer_pkg::reg_idx_t  addr;
    buzzer_pkg::word_t     wdata;
    buzzer_pkg::word_t     rdata;
    logic                  buzz;
    logic                  note_done;

    logic                  rd_check;
    buzzer_pkg::word_t     rd_expect;
    logic                  note_arm;
    logic                  note_close;
    buzzer_pkg::count_t    exp_freq;
    buzzer_pkg::count_t    exp_dur;
    logic                  exp_play;
    logic                  exp_silent;
    int                    chk_checks;
    int                    chk_errors;

    note_row_t             rows[$];
    logic                  rows_ready = 1'b0;
    logic [15:0]           lfsr_q;
    int                    seq_errors;
    buzzer_pkg::note_cnt_t notes_done;

    buzzer_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_stb   (bus_stb),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .buzz      (buzz),
        .note_done (note_done)
    );

    buzzer_checker i_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .buzz       (buzz),
        .note_done  (note_done),
        .rdata      (rdata),
        .rd_addr    (addr),
        .rd_check   (rd_check),
        .rd_expect  (rd_expect),
        .note_arm   (note_arm),
        .note_close (note_close),
        .exp_freq   (exp_freq),
        .exp_dur    (exp_dur),
        .exp_play   (exp_play),
        .exp_silent (exp_silent),
        .checks     (chk_checks),
        .errors     (chk_errors)
    );

    always #10 clk = ~clk;

    // Taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic draw_bits(input int n, output buzzer_pkg::count_t v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic add_row(input buzzer_pkg::count_t f, input buzzer_pkg::count_t d,
                           input buzzer_pkg::count_t a);
        note_row_t row;
        row.freq        = f;
        row.dur         = d;
        row.abort_after = a;
        rows.push_back(row);
    endtask

    function automatic buzzer_pkg::word_t stat_word(input logic err, input logic busy);
        return {notes_done, 14'b0, err, busy};
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic bus_write(input buzzer_pkg::reg_idx_t a, input buzzer_pkg::word_t d);
        @(posedge clk);
        #1;
        bus_stb = 1'b1;
        we      = 1'b1;
        addr    = a;
        wdata   = d;
        @(posedge clk);
        #1;
        bus_stb = 1'b0;
        we      = 1'b0;
    endtask

    task automatic read_expect(input buzzer_pkg::reg_idx_t a, input buzzer_pkg::word_t e);
        @(posedge clk);
        #1;
        addr      = a;
        rd_expect = e;
        rd_check  = 1'b1;
        @(posedge clk);
        #1;
        rd_check = 1'b0;
    endtask

    task automatic read_value(input buzzer_pkg::reg_idx_t a, output buzzer_pkg::word_t v);
        @(posedge clk);
        #1;
        addr = a;
        @(negedge clk);
        v = rdata;
    endtask

    task automatic arm_note(input note_row_t row, input logic play, input logic silent);
        @(posedge clk);
        #1;
        exp_freq   = row.freq;
        exp_dur    = row.dur;
        exp_play   = play;
        exp_silent = silent;
        note_arm   = 1'b1;
        @(posedge clk);
        #1;
        note_arm = 1'b0;
    endtask

    task automatic close_note();
        @(posedge clk);
        #1;
        note_close = 1'b1;
        @(posedge clk);
        #1;
        note_close = 1'b0;
    endtask

    task automatic wait_note_done();
        @(negedge clk);
        while (note_done !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic run_note(input note_row_t row);
        buzzer_pkg::count_t q;
        buzzer_pkg::word_t  v;
        logic               reject;
        logic               abort;
        int                 polls;
        q      = (row.freq == '0) ? '0 : buzzer_pkg::clk_hz / row.freq;
        reject = (q == '0);
        abort  = !reject && (row.abort_after != '0);
        bus_write(buzzer_pkg::reg_freq, row.freq);
        bus_write(buzzer_pkg::reg_dur, row.dur);
        read_expect(buzzer_pkg::reg_freq, row.freq);
        read_expect(buzzer_pkg::reg_dur, row.dur);
        arm_note(row, !reject && !abort, reject);
        // Upper ctrl bits are written as ones and must read back as zeros.
        bus_write(buzzer_pkg::reg_ctrl, 32'hFFFF_FFFF);
        read_expect(buzzer_pkg::reg_ctrl, 32'h0000_0001);
        read_expect(buzzer_pkg::reg_stat, stat_word(1'b0, 1'b1));
        bus_write(buzzer_pkg::reg_freq, ~row.freq);
        read_expect(buzzer_pkg::reg_freq, row.freq);
        if (reject) begin
            polls = 0;
            v     = 32'h1;
            while (v[0] && polls < buzzer_pkg::div_cycles + 10) begin
                read_value(buzzer_pkg::reg_ctrl, v);
                polls = polls + 1;
            end
            if (v[0]) begin
                seq_errors = seq_errors + 1;
                $display("A rejected note left the enable bit set");
            end
            close_note();
            read_expect(buzzer_pkg::reg_ctrl, 32'h0);
            read_expect(buzzer_pkg::reg_stat, stat_word(1'b1, 1'b0));
            bus_write(buzzer_pkg::reg_stat, 32'h0);
            read_expect(buzzer_pkg::reg_stat, stat_word(1'b0, 1'b0));
        end else if (abort) begin
            wait_cycles(int'(row.abort_after));
            bus_write(buzzer_pkg::reg_ctrl, 32'h0);
            // A divide in flight has to drain before the next note can start.
            wait_cycles(buzzer_pkg::div_cycles + 5);
            close_note();
            read_expect(buzzer_pkg::reg_ctrl, 32'h0);
            read_expect(buzzer_pkg::reg_stat, stat_word(1'b0, 1'b0));
        end else begin
            wait_note_done();
            notes_done = notes_done + 16'd1;
            close_note();
            read_expect(buzzer_pkg::reg_ctrl, 32'h0);
            read_expect(buzzer_pkg::reg_stat, stat_word(1'b0, 1'b0));
        end
    endtask

    initial begin : main
        buzzer_pkg::count_t r;
        buzzer_pkg::count_t qt;
        rst_n      = 1'b0;
        bus_stb    = 1'b0;
        we         = 1'b0;
        addr       = buzzer_pkg::reg_ctrl;
        wdata      = '0;
        rd_check   = 1'b0;
        rd_expect  = '0;
        note_arm   = 1'b0;
        note_close = 1'b0;
        exp_freq   = '0;
        exp_dur    = '0;
        exp_play   = 1'b0;
        exp_silent = 1'b0;
        seq_errors = 0;
        notes_done = '0;
        lfsr_q     = 16'd4673;

        add_row(32'd1_000_000, 32'd400, 32'd0);
        add_row(32'd5_000_000, 32'd100, 32'd0);
        add_row(32'd0, 32'd50, 32'd0);
        add_row(32'd60_000_000, 32'd50, 32'd0);
        add_row(32'd2_000_000, 32'd300, 32'd120);
        add_row(32'd2_500_000, 32'd200, 32'd10);
        add_row(32'd12_500_000, 32'd0, 32'd0);
        add_row(32'd25_000_000, 32'd7, 32'd0);
        add_row(32'd50_000_000, 32'd5, 32'd0);
        // Random notes with a half period of 2 to 40 cycles.
        repeat (6) begin
            draw_bits(6, r);
            qt = 32'd2 + (r % 32'd39);
            draw_bits(9, r);
            add_row(buzzer_pkg::clk_hz / qt, r % 32'd400, 32'd0);
        end
        rows_ready = 1'b1;

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        read_expect(buzzer_pkg::reg_ctrl, 32'h0);
        read_expect(buzzer_pkg::reg_freq, 32'h0);
        read_expect(buzzer_pkg::reg_dur, 32'h0);
        read_expect(buzzer_pkg::reg_stat, 32'h0);

        foreach (rows[i]) begin
            run_note(rows[i]);
        end
        wait_cycles(5);

        $display("Checks: %0d, checker errors: %0d, sequence errors: %0d",
                 chk_checks, chk_errors, seq_errors);
        if (chk_errors == 0 && seq_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin : watchdog
        longint cycles;
        wait (rows_ready);
        cycles = 0;
        foreach (rows[i]) begin
            cycles = cycles + longint'(buzzer_pkg::div_cycles) + longint'(rows[i].dur) + 20;
        end
        // Bus traffic, drain waits and reset cost well under 100 cycles per note.
        cycles = cycles + longint'(rows.size()) * 100 + 200;
        #(cycles * 20);
        $display("Timeout: the run did not complete within %0d clock cycles", cycles);
        $display("Checks failed");
        $finish;
    end

endmodule

/* buzzer_periph.f */
common/buzzer_pkg.sv
hdl/bus_regs.sv
tone_gen/period_div.sv
tone_gen/tone_gen.sv
hdl/buzz_out.sv
hdl/buzzer_top.sv
test/buzzer_checker.sv
test/buzzer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the buzzer testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module buzzer_tb \
    -f buzzer_periph.f \
    -o buzzer_sim

# The log decides the result, so a nonzero exit of the simulator is not fatal here.
./obj_dir/buzzer_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "All checks passed" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
